/* Makefile */
# Verilator flow for the audio mixing path

VERILATOR ?= verilator
TOP       ?= audio_mix_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation binary is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
hdl/audio_pkg.sv
hdl/volume_cmd.sv
hdl/channel_sum.sv
hdl/stereo_blend.sv
hdl/audio_mix_top.sv
testbench/audio_mix_chk.sv
testbench/audio_mix_tb.sv

/* hdl/audio_mix_top.sv */
module audio_mix_top import audio_pkg::*; #(
	parameter int STABLE_CYCLES = 2
) (
	input  logic    clk_sys,
	input  logic    resetd,
	input  logic    i_io_sel,
	input  logic    i_io_strobe,
	input  sample_t i_io_din,
	input  sample_t i_core_l,
	input  sample_t i_core_r,
	input  sample_t i_host_l,
	input  sample_t i_host_r,
	input  logic    i_core_signed,
	input  mix_t    i_mix,
	output sample_t o_audio_l,
	output sample_t o_audio_r
);

	att_t    att;
	sum_t    sum_l;
	sum_t    sum_r;
	sample_t pre_l;
	sample_t pre_r;

	////////////////////
	// Host command port
	////////////////////

	volume_cmd volume_cmd_i (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_sel    (i_io_sel),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_att       (att)
	);

	////////////////////
	// Channel front ends
	////////////////////

	channel_sum #(
		.STABLE_CYCLES (STABLE_CYCLES)
	) channel_sum_l_i (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_core        (i_core_l),
		.i_host        (i_host_l),
		.i_core_signed (i_core_signed),
		.o_sum         (sum_l),
		.o_pre         (pre_l)
	);

	channel_sum #(
		.STABLE_CYCLES (STABLE_CYCLES)
	) channel_sum_r_i (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_core        (i_core_r),
		.i_host        (i_host_r),
		.i_core_signed (i_core_signed),
		.o_sum         (sum_r),
		.o_pre         (pre_r)
	);

	////////////////////
	// Cross-feed, volume and clamp
	////////////////////

	// Each channel sees the other's half sum
	stereo_blend stereo_blend_i (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_sum_l   (sum_l),
		.i_sum_r   (sum_r),
		.i_pre_l   (pre_l),
		.i_pre_r   (pre_r),
		.i_mix     (i_mix),
		.i_att     (att),
		.o_audio_l (o_audio_l),
		.o_audio_r (o_audio_r)
	);

endmodule

/* hdl/audio_pkg.sv */
package audio_pkg;

	////////////////////
	// Sample and word types
	////////////////////

	// Audio sample or host I/O word
	typedef logic [15:0] sample_t;

	// Widened channel sum with one guard bit
	typedef logic signed [16:0] sum_t;

	// Bit 4 mutes, bits 3..0 give the right shift
	typedef logic [4:0] att_t;

	// Cross-feed amount between the channels
	typedef logic [1:0] mix_t;

	// Host command code, low byte of the first word
	typedef logic [7:0] cmd_t;

	////////////////////
	// Encodings
	////////////////////

	localparam mix_t MIX_NONE   = 2'd0;
	localparam mix_t MIX_LIGHT  = 2'd1;
	localparam mix_t MIX_MEDIUM = 2'd2;
	localparam mix_t MIX_FULL   = 2'd3;

	// Mute flag position inside att_t
	localparam int ATT_MUTE_BIT = 4;

	// Volume command, data word carries the attenuation
	localparam cmd_t CMD_VOLUME = 8'h26;

	// Command decoder states
	typedef enum logic {
		WAIT_CMD,
		TAKE_DATA
	} cmd_state_e;

endpackage

/* hdl/channel_sum.sv */
module channel_sum import audio_pkg::*; #(
	parameter int STABLE_CYCLES = 2
) (
	input  logic    clk_sys,
	input  logic    resetd,
	input  sample_t i_core,
	input  sample_t i_host,
	input  logic    i_core_signed,
	output sum_t    o_sum,
	output sample_t o_pre
);

	// Tap 0 is the first register after the input
	sample_t taps [0:STABLE_CYCLES];
	logic    stable;
	sample_t core_acc;
	sum_t    core_conv;
	sum_t    host_ext;
	sum_t    sum_next;

	////////////////////
	// Core stabilizer
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			for (int k = 0; k <= STABLE_CYCLES; k++) begin
				taps[k] <= '0;
			end
		end else begin
			taps[0] <= i_core;
			for (int k = 1; k <= STABLE_CYCLES; k++) begin
				taps[k] <= taps[k-1];
			end
		end
	end

	// Last STABLE_CYCLES taps must all hold the same value
	always_comb begin
		stable = 1'b1;
		for (int k = 1; k < STABLE_CYCLES; k++) begin
			if (taps[k] != taps[STABLE_CYCLES]) begin
				stable = 1'b0;
			end
		end
	end

	// Accepted core value, keeps the old one through glitches
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			core_acc <= '0;
		end else if (stable) begin
			core_acc <= taps[STABLE_CYCLES];
		end
	end

	////////////////////
	// Sign conversion and host add
	////////////////////

	// Unsigned core is halved so it fits the signed range
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			core_conv <= '0;
		end else if (i_core_signed) begin
			core_conv <= {core_acc[15], core_acc};
		end else begin
			core_conv <= {2'b00, core_acc[15:1]};
		end
	end

	assign host_ext = {i_host[15], i_host};
	assign sum_next = core_conv + host_ext;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_sum <= '0;
			o_pre <= '0;
		end else begin
			o_sum <= sum_next;
			// Half sum feeds the other channel's cross-feed
			o_pre <= sum_next[16:1];
		end
	end

endmodule

/* hdl/stereo_blend.sv */
module stereo_blend import audio_pkg::*; (
	input  logic    clk_sys,
	input  logic    resetd,
	input  sum_t    i_sum_l,
	input  sum_t    i_sum_r,
	input  sample_t i_pre_l,
	input  sample_t i_pre_r,
	input  mix_t    i_mix,
	input  att_t    i_att,
	output sample_t o_audio_l,
	output sample_t o_audio_r
);

	sum_t blend_l;
	sum_t blend_r;
	sum_t scaled_l;
	sum_t scaled_r;

	////////////////////
	// Per-sample helpers
	////////////////////

	// Own sum blended with the opposite channel's half sum
	function automatic sum_t blend_fn(input sum_t sum, input sample_t other_pre,
		input mix_t mode);
		sum_t pre_ext;
		sum_t res;
		pre_ext = {other_pre[15], other_pre};
		unique case (mode)
			MIX_NONE: begin
				res = sum;
			end
			MIX_LIGHT: begin
				res = sum - (sum >>> 3) + (pre_ext >>> 2);
			end
			MIX_MEDIUM: begin
				res = sum - (sum >>> 2) + (pre_ext >>> 1);
			end
			MIX_FULL: begin
				res = (sum >>> 1) + pre_ext;
			end
		endcase
		return res;
	endfunction

	// Mute or arithmetic shift down
	function automatic sum_t att_fn(input sum_t val, input att_t att);
		sum_t res;
		if (att[ATT_MUTE_BIT]) begin
			res = '0;
		end else begin
			res = val >>> att[3:0];
		end
		return res;
	endfunction

	// Saturate when the guard bit and the sign bit differ
	function automatic sample_t clamp_fn(input sum_t val);
		sample_t res;
		if (val[16] != val[15]) begin
			res = {val[16], {15{val[15]}}};
		end else begin
			res = val[15:0];
		end
		return res;
	endfunction

	////////////////////
	// Blend stage
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			blend_l <= '0;
			blend_r <= '0;
		end else begin
			blend_l <= blend_fn(i_sum_l, i_pre_r, i_mix);
			blend_r <= blend_fn(i_sum_r, i_pre_l, i_mix);
		end
	end

	////////////////////
	// Attenuation stage
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			scaled_l <= '0;
			scaled_r <= '0;
		end else begin
			scaled_l <= att_fn(blend_l, i_att);
			scaled_r <= att_fn(blend_r, i_att);
		end
	end

	////////////////////
	// Clamp stage
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_audio_l <= '0;
			o_audio_r <= '0;
		end else begin
			o_audio_l <= clamp_fn(scaled_l);
			o_audio_r <= clamp_fn(scaled_r);
		end
	end

endmodule

/* hdl/volume_cmd.sv */
module volume_cmd import audio_pkg::*; (
	input  logic    clk_sys,
	input  logic    resetd,
	input  logic    i_io_sel,
	input  logic    i_io_strobe,
	input  sample_t i_io_din,
	output att_t    o_att
);

	logic       strobe_d;
	logic       strobe_rise;
	cmd_state_e state;
	cmd_t       cmd_q;
	logic       att_wr;
	att_t       att_pend;

	////////////////////
	// Strobe edge
	////////////////////

	// Only the rising edge of the level strobe counts as a word
	assign strobe_rise = i_io_strobe & ~strobe_d;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			strobe_d <= 1'b0;
		end else begin
			strobe_d <= i_io_strobe;
		end
	end

	////////////////////
	// Command FSM
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state  <= WAIT_CMD;
			cmd_q  <= '0;
			att_wr <= 1'b0;
		end else begin
			att_wr <= 1'b0;
			if (!i_io_sel) begin
				// Deselect ends the command, setting stays
				state <= WAIT_CMD;
			end else if (strobe_rise) begin
				case (state)
					WAIT_CMD: begin
						cmd_q <= i_io_din[7:0];
						state <= TAKE_DATA;
					end
					TAKE_DATA: begin
						// Data for any other command is dropped
						if (cmd_q == CMD_VOLUME) begin
							att_wr <= 1'b1;
						end
					end
					default: begin
						state <= WAIT_CMD;
					end
				endcase
			end
		end
	end

	// Data word held for the write one cycle later
	always_ff @(posedge clk_sys) begin
		if (strobe_rise) begin
			att_pend <= i_io_din[4:0];
		end
	end

	////////////////////
	// Attenuation register
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_att <= '0;
		end else if (att_wr) begin
			o_att <= att_pend;
		end
	end

endmodule

/* testbench/audio_mix_chk.sv */
module audio_mix_chk import audio_pkg::*; (
	input logic    clk_sys,
	input logic    resetd,
	input logic    i_io_sel,
	input logic    i_io_strobe,
	input att_t    att,
	input sample_t o_audio_l,
	input sample_t o_audio_r
);

	logic strobe_q;
	logic take_q1;
	logic take_q2;

	// Selected strobe rise, delayed to line up with the attenuation write
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			strobe_q <= 1'b0;
			take_q1  <= 1'b0;
			take_q2  <= 1'b0;
		end else begin
			strobe_q <= i_io_strobe;
			take_q1  <= i_io_sel & i_io_strobe & ~strobe_q;
			take_q2  <= take_q1;
		end
	end

	out_reset_clear: assert property (@(posedge clk_sys)
		resetd |=> (o_audio_l == '0 && o_audio_r == '0))
		else $error("audio outputs not cleared after reset");

	att_on_strobe: assert property (@(posedge clk_sys) disable iff (resetd)
		($changed(att) && !$past(resetd)) |-> take_q2)
		else $error("attenuation changed without a selected strobe two cycles before");

	att_held_deselected: assert property (@(posedge clk_sys) disable iff (resetd)
		(!$past(i_io_sel, 2) && !$past(resetd)) |-> $stable(att))
		else $error("attenuation changed while the bus was deselected");

endmodule

bind audio_mix_top audio_mix_chk audio_mix_chk_i (
	.clk_sys     (clk_sys),
	.resetd      (resetd),
	.i_io_sel    (i_io_sel),
	.i_io_strobe (i_io_strobe),
	.att         (att),
	.o_audio_l   (o_audio_l),
	.o_audio_r   (o_audio_r)
);

/* testbench/audio_mix_input.txt */
# Hex columns. H core_l core_r host_l host_r signed mix exp_l exp_r
# G is H plus glitch_l glitch_r. S selects, W strobes one word, D deselects
# Reset state
H 0000 0000 0000 0000 1 0 0000 0000
# Plain mixing and saturation
H 1234 f000 0100 0200 1 0 1334 f200
H 7000 9000 3000 c000 1 0 7fff 8000
# Unsigned core
H 8000 fffe 0010 ffff 0 0 4010 7ffe
H 0000 fffe 0000 0100 0 0 0000 7fff
# Cross-feed modes
H 1f00 f800 0100 f800 1 1 1a00 f600
H 1f00 f800 0100 f800 1 2 1400 fc00
H 1f00 f800 0100 f800 1 3 0800 0800
H fffd 0003 fffe 0004 1 1 fffc 0006
H fffd 0003 fffe 0004 1 2 fffe 0004
H 7000 4000 3000 3000 1 3 7fff 7fff
H 7000 4000 3000 3000 1 1 7fff 7600
H 9000 9000 d000 0000 1 2 8000 8400
# Volume, shift by 2
S
W 0026
W 0002
D
H 1f00 f800 0100 f800 1 0 0800 fc00
H 7000 fffd 3000 fffe 1 0 2800 fffe
# Data of another command
S
W 0011
W 0010
D
H 1f00 f800 0100 f800 1 0 0800 fc00
# Word while deselected
W 0010
H 1f00 f800 0100 f800 1 0 0800 fc00
# Shift by 3, then reselect where the first word is a command
S
W 0026
W 0003
D
S
W 0010
D
H 1f00 f800 0100 f800 1 0 0400 fe00
H 1f00 f800 0100 f800 1 1 0340 fec0
# Mute
S
W 0026
W 0010
D
H 7000 9000 3000 c000 1 0 0000 0000
# Two data words, last one holds
S
W 0026
W 0001
W 0000
D
H 1234 f000 0100 0200 1 0 1334 f200
# Glitch filtering
H 1f00 f800 0100 f800 1 0 2000 f000
G 1f00 f800 0100 f800 1 0 2000 f000 5555 aaaa

/* testbench/audio_mix_tb.sv */
module audio_mix_tb import audio_pkg::*; ();

	localparam int    HALF_PERIOD    = 4;
	localparam int    DRIVE_DELAY    = 1;
	localparam int    RESET_CYCLES   = 8;
	localparam int    HOLD_CYCLES    = 16;
	localparam int    SETTLE_CYCLES  = 10;
	localparam int    GLITCH_AT      = 12;
	localparam int    GLITCH_ROW_LEN = 28;
	localparam int    WAIT_LIMIT     = 20;
	localparam string INPUT_FILE     = "testbench/audio_mix_input.txt";

	logic    clk_sys = 1'b0;
	logic    resetd;
	logic    i_io_sel;
	logic    i_io_strobe;
	sample_t i_io_din;
	sample_t i_core_l;
	sample_t i_core_r;
	sample_t i_host_l;
	sample_t i_host_r;
	logic    i_core_signed;
	mix_t    i_mix;
	sample_t o_audio_l;
	sample_t o_audio_r;

	audio_mix_top audio_mix_top_i (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_io_sel      (i_io_sel),
		.i_io_strobe   (i_io_strobe),
		.i_io_din      (i_io_din),
		.i_core_l      (i_core_l),
		.i_core_r      (i_core_r),
		.i_host_l      (i_host_l),
		.i_host_r      (i_host_r),
		.i_core_signed (i_core_signed),
		.i_mix         (i_mix),
		.o_audio_l     (o_audio_l),
		.o_audio_r     (o_audio_r)
	);

	always #HALF_PERIOD clk_sys = ~clk_sys;

	////////////////////
	// Helpers
	////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_sample(input string what, input sample_t got, input sample_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
			abort_run("output sample mismatch");
		end
	endtask

	// Inputs change just after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#DRIVE_DELAY;
	endtask

	// Registered strobe copy inside the decoder shows the level was taken
	task automatic wait_strobe_seen(input logic level);
		int count;
		count = 0;
		while (audio_mix_top_i.volume_cmd_i.strobe_d !== level) begin
			if (count == WAIT_LIMIT) begin
				abort_run("timeout: the decoder never registered the strobe level");
			end else begin
				next_cycle();
				count++;
			end
		end
	endtask

	task automatic wait_decoder_idle();
		int count;
		count = 0;
		while (audio_mix_top_i.volume_cmd_i.state != WAIT_CMD) begin
			if (count == WAIT_LIMIT) begin
				abort_run("timeout: the decoder did not return to waiting for a command");
			end else begin
				next_cycle();
				count++;
			end
		end
	endtask

	task automatic send_word(input sample_t word);
		i_io_din    = word;
		i_io_strobe = 1'b1;
		wait_strobe_seen(1'b1);
		i_io_strobe = 1'b0;
		wait_strobe_seen(1'b0);
	endtask

	task automatic set_select(input logic level);
		i_io_sel = level;
		next_cycle();
		wait_decoder_idle();
	endtask

	task automatic drive_samples(input sample_t core_l, input sample_t core_r,
		input sample_t host_l, input sample_t host_r, input logic sgn, input mix_t mix);
		i_core_l      = core_l;
		i_core_r      = core_r;
		i_host_l      = host_l;
		i_host_r      = host_r;
		i_core_signed = sgn;
		i_mix         = mix;
	endtask

	task automatic hold_row(input int line_no, input sample_t core_l, input sample_t core_r,
		input sample_t host_l, input sample_t host_r, input logic sgn, input mix_t mix,
		input sample_t exp_l, input sample_t exp_r);
		drive_samples(core_l, core_r, host_l, host_r, sgn, mix);
		repeat (HOLD_CYCLES) next_cycle();
		check_sample($sformatf("left output, line %0d", line_no), o_audio_l, exp_l);
		check_sample($sformatf("right output, line %0d", line_no), o_audio_r, exp_r);
	endtask

	// One-cycle core glitch in a steady row with outputs watched every cycle
	task automatic glitch_row(input int line_no, input sample_t core_l, input sample_t core_r,
		input sample_t host_l, input sample_t host_r, input logic sgn, input mix_t mix,
		input sample_t exp_l, input sample_t exp_r, input sample_t glitch_l,
		input sample_t glitch_r);
		drive_samples(core_l, core_r, host_l, host_r, sgn, mix);
		for (int cyc = 0; cyc < GLITCH_ROW_LEN; cyc++) begin
			if (cyc == GLITCH_AT) begin
				i_core_l = glitch_l;
				i_core_r = glitch_r;
			end else begin
				i_core_l = core_l;
				i_core_r = core_r;
			end
			next_cycle();
			if (cyc >= SETTLE_CYCLES) begin
				check_sample($sformatf("left output, line %0d", line_no), o_audio_l, exp_l);
				check_sample($sformatf("right output, line %0d", line_no), o_audio_r, exp_r);
			end
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		int         fd;
		int         n;
		int         line_no;
		int         rows;
		string      line;
		logic [7:0] kind;
		sample_t    cl;
		sample_t    cr;
		sample_t    hl;
		sample_t    hr;
		sample_t    el;
		sample_t    er;
		sample_t    gl;
		sample_t    gr;
		sample_t    word;
		logic       sg;
		mix_t       mx;
		line_no     = 0;
		rows        = 0;
		resetd      = 1'b1;
		i_io_sel    = 1'b0;
		i_io_strobe = 1'b0;
		i_io_din    = '0;
		drive_samples('0, '0, '0, '0, 1'b1, MIX_NONE);
		repeat (RESET_CYCLES) next_cycle();
		resetd = 1'b0;
		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0) begin
			abort_run($sformatf("cannot open stimulus file %s", INPUT_FILE));
		end
		while ($fgets(line, fd) != 0) begin
			line_no++;
			// Comment and blank lines carry no row
			if (line.len() > 1 && line.getc(0) != "#") begin
				kind = line.getc(0);
				case (kind)
					"H": begin
						n = $sscanf(line, "H %h %h %h %h %h %h %h %h",
							cl, cr, hl, hr, sg, mx, el, er);
						if (n != 8) begin
							abort_run($sformatf("malformed sample row at line %0d", line_no));
						end else begin
							hold_row(line_no, cl, cr, hl, hr, sg, mx, el, er);
						end
					end
					"G": begin
						n = $sscanf(line, "G %h %h %h %h %h %h %h %h %h %h",
							cl, cr, hl, hr, sg, mx, el, er, gl, gr);
						if (n != 10) begin
							abort_run($sformatf("malformed glitch row at line %0d", line_no));
						end else begin
							glitch_row(line_no, cl, cr, hl, hr, sg, mx, el, er, gl, gr);
						end
					end
					"W": begin
						n = $sscanf(line, "W %h", word);
						if (n != 1) begin
							abort_run($sformatf("malformed word row at line %0d", line_no));
						end else begin
							send_word(word);
						end
					end
					"S": set_select(1'b1);
					"D": set_select(1'b0);
					default: begin
						abort_run($sformatf("unknown row kind at line %0d", line_no));
					end
				endcase
				rows++;
			end
		end
		$fclose(fd);
		if (rows == 0) begin
			abort_run("stimulus file holds no rows");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule
